// ==== design/issuePkg.sv ====
package issuePkg;

    // Datapath and field widths
    localparam int dataWidth     = 16;
    localparam int regAddrWidth  = 4;
    localparam int memAddrWidth  = 8;
    localparam int minorOpWidth  = 4;
    localparam int unitEnWidth   = 5;
    localparam int wbSourceWidth = 2;

    // Bit positions in unitEnable
    localparam int enAlu0    = 0;
    localparam int enAlu1    = 1;
    localparam int enComplex = 2;
    localparam int enMem     = 3;
    localparam int enBranch  = 4;

    // ALU minor opcodes
    localparam logic [minorOpWidth-1:0] opAdd   = 4'd0;
    localparam logic [minorOpWidth-1:0] opSub   = 4'd1;
    localparam logic [minorOpWidth-1:0] opAnd   = 4'd2;
    localparam logic [minorOpWidth-1:0] opOr    = 4'd3;
    localparam logic [minorOpWidth-1:0] opXor   = 4'd4;
    localparam logic [minorOpWidth-1:0] opShl   = 4'd5;
    localparam logic [minorOpWidth-1:0] opShr   = 4'd6;
    localparam logic [minorOpWidth-1:0] opSra   = 4'd7;
    localparam logic [minorOpWidth-1:0] opSlt   = 4'd8;
    localparam logic [minorOpWidth-1:0] opSltu  = 4'd9;
    localparam logic [minorOpWidth-1:0] opPassB = 4'd10;

    // Branch minor opcodes
    localparam logic [minorOpWidth-1:0] brEq     = 4'd0;
    localparam logic [minorOpWidth-1:0] brNe     = 4'd1;
    localparam logic [minorOpWidth-1:0] brLt     = 4'd2;
    localparam logic [minorOpWidth-1:0] brLtu    = 4'd3;
    localparam logic [minorOpWidth-1:0] brAlways = 4'd4;

    // Memory minor opcodes
    localparam logic [minorOpWidth-1:0] memLoad  = 4'd0;
    localparam logic [minorOpWidth-1:0] memStore = 4'd1;

    // Writeback source select
    localparam logic [wbSourceWidth-1:0] wbAlu0   = 2'd0;
    localparam logic [wbSourceWidth-1:0] wbAlu1   = 2'd1;
    localparam logic [wbSourceWidth-1:0] wbMem    = 2'd2;
    localparam logic [wbSourceWidth-1:0] wbBranch = 2'd3;

    typedef struct packed {
        logic [minorOpWidth-1:0]  minorOpcode;
        logic [unitEnWidth-1:0]   unitEnable;
        logic [wbSourceWidth-1:0] wbSource;
        logic                     wbEn;
        logic [regAddrWidth-1:0]  wbAddr;
        logic [dataWidth-1:0]     dataA;
        logic [dataWidth-1:0]     dataB;
    } issueInstrT;

    // Same operand bundle goes to every unit
    typedef struct packed {
        logic [minorOpWidth-1:0] minorOpcode;
        logic [dataWidth-1:0]    dataA;
        logic [dataWidth-1:0]    dataB;
    } unitOpT;

    typedef struct packed {
        logic                     en;
        logic [wbSourceWidth-1:0] source;
        logic [regAddrWidth-1:0]  addr;
    } wbCtrlT;

    typedef struct packed {
        logic                    en;
        logic [regAddrWidth-1:0] addr;
        logic [dataWidth-1:0]    data;
    } wbResultT;

endpackage

// ==== design/instructionIssue.sv ====
`timescale 1ns/10ps

module instructionIssue (
    input  logic                 clk,
    input  logic                 arstN,
    input  issuePkg::issueInstrT instr,
    input  logic                 memReady,
    output issuePkg::unitOpT     unitOp,
    output logic                 alu0En,
    output logic                 alu1En,
    output logic                 branchEn,
    output logic                 memIssue,
    output logic                 stall,
    output issuePkg::wbCtrlT     wbCtrl
);

    import issuePkg::*;

    // Set while a memory request waits for the load/store unit
    logic stallBuf;

    // Opcode and operands are broadcast, the strobes pick the unit
    assign unitOp.minorOpcode = instr.minorOpcode;
    assign unitOp.dataA       = instr.dataA;
    assign unitOp.dataB       = instr.dataB;

    // One-hot unit strobes, complex lane bit is ignored
    assign alu0En   = instr.unitEnable[enAlu0];
    assign alu1En   = instr.unitEnable[enAlu1];
    assign branchEn = instr.unitEnable[enBranch];

    // Request level toward the load/store unit
    assign memIssue = instr.unitEnable[enMem] | stallBuf;

    // Hold upstream while the unit is still recovering
    assign stall = memIssue & ~memReady;

    // Writeback control travels on to the writeback stage
    assign wbCtrl.en     = instr.wbEn;
    assign wbCtrl.source = instr.wbSource;
    assign wbCtrl.addr   = instr.wbAddr;

    // Reloaded on every request cycle, so it clears once accepted
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stallBuf <= 1'b0;
        end else if (memIssue) begin
            stallBuf <= ~memReady;
        end
    end

endmodule

// ==== design/simpleAlu.sv ====
`timescale 1ns/10ps

module simpleAlu (
    input  issuePkg::unitOpT                    unitOp,
    input  logic                                en,
    output logic [issuePkg::dataWidth-1:0]      result
);

    import issuePkg::*;

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [3:0]           shamt;
    logic [dataWidth-1:0] aluOut;

    assign opA   = unitOp.dataA;
    assign opB   = unitOp.dataB;
    // Shift amount from the low bits of B
    assign shamt = opB[3:0];

    always_comb begin
        case (unitOp.minorOpcode)
            opAdd:   aluOut = opA + opB;
            opSub:   aluOut = opA - opB;
            opAnd:   aluOut = opA & opB;
            opOr:    aluOut = opA | opB;
            opXor:   aluOut = opA ^ opB;
            opShl:   aluOut = opA << shamt;
            opShr:   aluOut = opA >> shamt;
            opSra:   aluOut = $unsigned($signed(opA) >>> shamt);
            opSlt: begin
                aluOut = {{(dataWidth-1){1'b0}}, ($signed(opA) < $signed(opB))};
            end
            opSltu: begin
                aluOut = {{(dataWidth-1){1'b0}}, (opA < opB)};
            end
            opPassB: aluOut = opB;
            // Unassigned codes
            default: aluOut = '0;
        endcase
    end

    // Idle lane drives zero
    assign result = en ? aluOut : '0;

endmodule

// ==== design/branchUnit.sv ====
`timescale 1ns/10ps

module branchUnit (
    input  logic                               clk,
    input  logic                               arstN,
    input  issuePkg::unitOpT                   unitOp,
    input  logic                               en,
    output logic                               taken,
    output logic [issuePkg::dataWidth-1:0]     target,
    output logic [issuePkg::dataWidth-1:0]     compareFlag
);

    import issuePkg::*;

    logic condMet;

    always_comb begin
        case (unitOp.minorOpcode)
            brEq:     condMet = (unitOp.dataA == unitOp.dataB);
            brNe:     condMet = (unitOp.dataA != unitOp.dataB);
            brLt:     condMet = ($signed(unitOp.dataA) < $signed(unitOp.dataB));
            brLtu:    condMet = (unitOp.dataA < unitOp.dataB);
            brAlways: condMet = 1'b1;
            default:  condMet = 1'b0;
        endcase
    end

    // Taken only pulses for the cycle after a branch issue
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            taken <= 1'b0;
        end else begin
            taken <= en & condMet;
        end
    end

    // Target and flag hold until the next branch
    always_ff @(posedge clk) begin
        if (en) begin
            target      <= unitOp.dataB;
            compareFlag <= {{(dataWidth-1){1'b0}}, condMet};
        end
    end

endmodule

// ==== design/loadStoreUnit.sv ====
`timescale 1ns/10ps

module loadStoreUnit (
    input  logic                               clk,
    input  logic                               arstN,
    input  issuePkg::unitOpT                   unitOp,
    input  logic                               memIssue,
    output logic                               memReady,
    output logic [issuePkg::dataWidth-1:0]     loadData
);

    import issuePkg::*;

    localparam int memDepth = 1 << memAddrWidth;

    logic [dataWidth-1:0]    mem [memDepth];
    logic [memAddrWidth-1:0] addr;
    logic                    accept;
    logic                    isStore;
    logic                    readyQ;

    // Word address from the low bits of A
    assign addr    = unitOp.dataA[memAddrWidth-1:0];
    assign isStore = (unitOp.minorOpcode == memStore);

    // Request and readiness both high at the edge
    assign accept = memIssue & readyQ;

    assign memReady = readyQ;

    // One recovery cycle after every accepted access
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            readyQ <= 1'b1;
        end else begin
            readyQ <= ~accept;
        end
    end

    // Single write port
    always_ff @(posedge clk) begin
        if (accept && isStore) begin
            mem[addr] <= unitOp.dataB;
        end
    end

    // Load word is registered at the accepting edge
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            loadData <= '0;
        end else if (accept && !isStore) begin
            loadData <= mem[addr];
        end
    end

endmodule

// ==== design/writebackSelect.sv ====
`timescale 1ns/10ps

module writebackSelect (
    input  logic                               clk,
    input  logic                               arstN,
    input  issuePkg::wbCtrlT                   wbCtrl,
    input  logic                               stall,
    input  logic [issuePkg::dataWidth-1:0]     alu0Result,
    input  logic [issuePkg::dataWidth-1:0]     alu1Result,
    input  logic [issuePkg::dataWidth-1:0]     branchFlag,
    input  logic [issuePkg::dataWidth-1:0]     loadData,
    output issuePkg::wbResultT                 wb
);

    import issuePkg::*;

    wbCtrlT               ctrlQ;
    logic [dataWidth-1:0] alu0Q;
    logic [dataWidth-1:0] alu1Q;

    // A stalled instruction retires later, so its write is dropped here
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrlQ <= '0;
        end else begin
            ctrlQ.en     <= wbCtrl.en & ~stall;
            ctrlQ.source <= wbCtrl.source;
            ctrlQ.addr   <= wbCtrl.addr;
        end
    end

    // ALU results delayed to line up with load data and branch flag
    always_ff @(posedge clk) begin
        alu0Q <= alu0Result;
        alu1Q <= alu1Result;
    end

    assign wb.en   = ctrlQ.en;
    assign wb.addr = ctrlQ.addr;

    always_comb begin
        case (ctrlQ.source)
            wbAlu0:   wb.data = alu0Q;
            wbAlu1:   wb.data = alu1Q;
            wbMem:    wb.data = loadData;
            wbBranch: wb.data = branchFlag;
            default:  wb.data = '0;
        endcase
    end

endmodule

// ==== design/executeCore.sv ====
`timescale 1ns/10ps

module executeCore (
    input  logic                               clk,
    input  logic                               arstN,
    input  issuePkg::issueInstrT               instr,
    output logic                               stall,
    output logic                               branchTaken,
    output logic [issuePkg::dataWidth-1:0]     branchTarget,
    output issuePkg::wbResultT                 wb
);

    import issuePkg::*;

    unitOpT               unitOp;
    wbCtrlT               wbCtrl;
    logic                 alu0En;
    logic                 alu1En;
    logic                 branchEn;
    logic                 memIssue;
    logic                 memReady;
    logic [dataWidth-1:0] alu0Result;
    logic [dataWidth-1:0] alu1Result;
    logic [dataWidth-1:0] compareFlag;
    logic [dataWidth-1:0] loadData;

    instructionIssue issue0 (
        .clk      (clk),
        .arstN    (arstN),
        .instr    (instr),
        .memReady (memReady),
        .unitOp   (unitOp),
        .alu0En   (alu0En),
        .alu1En   (alu1En),
        .branchEn (branchEn),
        .memIssue (memIssue),
        .stall    (stall),
        .wbCtrl   (wbCtrl)
    );

    // Two identical simple lanes
    simpleAlu alu0 (
        .unitOp (unitOp),
        .en     (alu0En),
        .result (alu0Result)
    );

    simpleAlu alu1 (
        .unitOp (unitOp),
        .en     (alu1En),
        .result (alu1Result)
    );

    branchUnit branch0 (
        .clk         (clk),
        .arstN       (arstN),
        .unitOp      (unitOp),
        .en          (branchEn),
        .taken       (branchTaken),
        .target      (branchTarget),
        .compareFlag (compareFlag)
    );

    loadStoreUnit lsu0 (
        .clk      (clk),
        .arstN    (arstN),
        .unitOp   (unitOp),
        .memIssue (memIssue),
        .memReady (memReady),
        .loadData (loadData)
    );

    writebackSelect wbSel0 (
        .clk        (clk),
        .arstN      (arstN),
        .wbCtrl     (wbCtrl),
        .stall      (stall),
        .alu0Result (alu0Result),
        .alu1Result (alu1Result),
        .branchFlag (compareFlag),
        .loadData   (loadData),
        .wb         (wb)
    );

endmodule

// ==== test/clockGen.sv ====
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic arstN
);

    // 40 ns period
    always #20 clk = ~clk;

    // Reset spans five rising edges and lifts on a falling edge
    initial begin
        clk   = 1'b0;
        arstN = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

// ==== test/executeCore_properties.sv ====
`timescale 1ns/10ps

module executeCoreProperties (
    input logic clk,
    input logic arstN,
    input logic stall,
    input logic memIssue,
    input logic memReady
);

    // An accepted access is followed by the recovery cycle
    acceptThenBusy: assert property (@(posedge clk) disable iff (!arstN)
        (memIssue && memReady) |=> !memReady)
        else $error("memReady stayed high after an accepted access");

    // The held request is presented and accepted right after a stall
    stallThenIssue: assert property (@(posedge clk) disable iff (!arstN)
        stall |=> (memIssue && memReady))
        else $error("held memory request not accepted after a stall cycle");

    // Recovery lasts one cycle only
    readyRecovers: assert property (@(posedge clk) disable iff (!arstN)
        !memReady |=> memReady)
        else $error("memReady stayed low for two cycles");

endmodule

bind instructionIssue executeCoreProperties props0 (
    .clk      (clk),
    .arstN    (arstN),
    .stall    (stall),
    .memIssue (memIssue),
    .memReady (memReady)
);

// ==== test/executeCoreTb.sv ====
`timescale 1ns/10ps

module executeCoreTb;

    import issuePkg::*;

    logic                 clk;
    logic                 arstN;
    issueInstrT           instr;
    logic                 stall;
    logic                 branchTaken;
    logic [dataWidth-1:0] branchTarget;
    wbResultT             wb;

    int numInstr = 400;
    int periodNs = 40;
    int errors;
    int checks;
    int issued;
    logic [31:0] lcgState;

    // Reference model state
    issueInstrT  cur;
    logic        holdInstr;
    logic        readyM;
    logic        stallBufM;
    logic [15:0] loadM;
    logic [15:0] memModel [256];
    logic        expStall;
    wbResultT    expWb;
    logic        expTaken;
    logic [15:0] expTarget;
    logic        checkTarget;

    clockGen clkGen0 (
        .clk   (clk),
        .arstN (arstN)
    );

    executeCore dut0 (
        .clk          (clk),
        .arstN        (arstN),
        .instr        (instr),
        .stall        (stall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .wb           (wb)
    );

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [15:0] aluRef(input logic [3:0] op, input logic [15:0] a,
                                           input logic [15:0] b);
        logic [31:0] ext;
        logic [3:0]  sh;
        sh  = b[3:0];
        ext = {{16{a[15]}}, a};
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opXor:   return a ^ b;
            opShl:   return a << sh;
            opShr:   return a >> sh;
            opSra:   return 16'(ext >> sh);
            // Signed compare by flipping the sign bits
            opSlt:   return ((a ^ 16'h8000) < (b ^ 16'h8000)) ? 16'd1 : 16'd0;
            opSltu:  return (a < b) ? 16'd1 : 16'd0;
            opPassB: return b;
            default: return 16'd0;
        endcase
    endfunction

    function automatic logic branchRef(input logic [3:0] op, input logic [15:0] a,
                                       input logic [15:0] b);
        case (op)
            brEq:     return a == b;
            brNe:     return a != b;
            brLt:     return (a ^ 16'h8000) < (b ^ 16'h8000);
            brLtu:    return a < b;
            brAlways: return 1'b1;
            default:  return 1'b0;
        endcase
    endfunction

    // One enabled unit per instruction, first 16 are stores to words 0..15
    function automatic issueInstrT makeInstr(input int idx);
        issueInstrT ins;
        logic [31:0] r;
        logic [31:0] s;
        ins = '0;
        r = nextRand();
        s = nextRand();
        ins.dataA  = r[31:16];
        ins.dataB  = s[31:16];
        ins.wbAddr = r[11:8];
        ins.wbEn   = (s[10:8] != 3'd0);
        if (idx < 16) begin
            ins.unitEnable[enMem] = 1'b1;
            ins.minorOpcode       = memStore;
            ins.dataA             = 16'(idx);
            ins.wbSource          = wbMem;
            ins.wbEn              = 1'b0;
        end else begin
            case (r[14:13])
                2'd0: begin
                    ins.unitEnable[enAlu0] = 1'b1;
                    ins.minorOpcode        = s[15:12];
                    ins.wbSource           = wbAlu0;
                end
                2'd1: begin
                    ins.unitEnable[enAlu1] = 1'b1;
                    ins.minorOpcode        = s[15:12];
                    ins.wbSource           = wbAlu1;
                end
                2'd2: begin
                    ins.unitEnable[enMem] = 1'b1;
                    ins.minorOpcode       = {3'b000, s[12]};
                    ins.dataA             = {r[31:24], 4'h0, r[19:16]};
                    ins.wbSource          = wbMem;
                    if (ins.minorOpcode == memStore) begin
                        ins.wbEn = 1'b0;
                    end
                end
                default: begin
                    ins.unitEnable[enBranch] = 1'b1;
                    ins.minorOpcode          = {1'b0, s[14:12]};
                    ins.wbSource             = wbBranch;
                    // Equal operands now and then
                    if (s[11]) begin
                        ins.dataB = ins.dataA;
                    end
                end
            endcase
        end
        return ins;
    endfunction

    // Advances the model by one cycle for the instruction now on instr
    task automatic stepModel;
        logic memIssueM;
        logic acceptM;
        logic condM;
        memIssueM = cur.unitEnable[enMem] | stallBufM;
        expStall  = memIssueM & ~readyM;
        acceptM   = memIssueM & readyM;
        if (acceptM && cur.minorOpcode == memStore) begin
            memModel[cur.dataA[7:0]] = cur.dataB;
        end else if (acceptM) begin
            loadM = memModel[cur.dataA[7:0]];
        end
        if (memIssueM) begin
            stallBufM = ~readyM;
        end
        readyM = ~acceptM;
        condM       = branchRef(cur.minorOpcode, cur.dataA, cur.dataB);
        expTaken    = cur.unitEnable[enBranch] & condM;
        checkTarget = cur.unitEnable[enBranch];
        expTarget   = cur.dataB;
        expWb.en    = cur.wbEn & ~expStall;
        expWb.addr  = cur.wbAddr;
        case (cur.wbSource)
            wbAlu0: begin
                expWb.data = cur.unitEnable[enAlu0] ?
                             aluRef(cur.minorOpcode, cur.dataA, cur.dataB) : 16'd0;
            end
            wbAlu1: begin
                expWb.data = cur.unitEnable[enAlu1] ?
                             aluRef(cur.minorOpcode, cur.dataA, cur.dataB) : 16'd0;
            end
            wbMem:   expWb.data = loadM;
            default: expWb.data = {15'd0, condM};
        endcase
    endtask

    task automatic checkOutputs;
        checkValue("wb.en", 16'(wb.en), 16'(expWb.en));
        if (expWb.en) begin
            checkValue("wb.addr", 16'(wb.addr), 16'(expWb.addr));
            checkValue("wb.data", wb.data, expWb.data);
        end
        checkValue("branchTaken", 16'(branchTaken), 16'(expTaken));
        if (checkTarget) begin
            checkValue("branchTarget", branchTarget, expTarget);
        end
    endtask

    initial begin
        instr       = '0;
        cur         = '0;
        lcgState    = 32'd81;
        errors      = 0;
        checks      = 0;
        issued      = 0;
        holdInstr   = 1'b0;
        readyM      = 1'b1;
        stallBufM   = 1'b0;
        loadM       = 16'd0;
        expWb       = '0;
        expTaken    = 1'b0;
        expTarget   = 16'd0;
        checkTarget = 1'b0;
        wait (arstN === 1'b1);
        #1;
        checkValue("wb.en", 16'(wb.en), 16'd0);
        checkValue("stall", 16'(stall), 16'd0);
        checkValue("branchTaken", 16'(branchTaken), 16'd0);
        while (issued < numInstr) begin
            @(negedge clk);
            checkOutputs();
            if (!holdInstr) begin
                cur = makeInstr(issued);
            end
            instr = cur;
            stepModel();
            holdInstr = expStall;
            if (!expStall) begin
                issued++;
            end
            #1;
            checkValue("stall", 16'(stall), 16'(expStall));
        end
        @(negedge clk);
        checkOutputs();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Reset time plus 60 cycles per instruction
    initial begin
        #((6 + numInstr * 60) * periodNs);
        $display("Timeout: the instruction stream did not complete in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== all.f ====
design/issuePkg.sv
design/instructionIssue.sv
design/simpleAlu.sv
design/branchUnit.sv
design/loadStoreUnit.sv
design/writebackSelect.sv
design/executeCore.sv
test/clockGen.sv
test/executeCore_properties.sv
test/executeCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the execute core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module executeCoreTb -f all.f -o executeCoreSim

# An assertion failure ends the binary with a nonzero status
./obj_dir/executeCoreSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Testbench passed$" sim.log; then
    exit 0
fi
echo "run.sh: simulation did not pass"
exit 1
